// ==== source/srd_cfg.svh ====
/* Symbol-rate divider build configuration
   Sample width, base divide, identity and APB address width */

`ifndef SRD_CFG_SVH
`define SRD_CFG_SVH

//////////////////////////////
// Sample stream
//////////////////////////////

// Width of each of I and Q
`define SRD_SAMPLE_W 16

// Repeat count at full rate, 1 to 3 supported
`define SRD_BASE_DIV 1

//////////////////////////////
// Register block
//////////////////////////////

`define SRD_MODULE_ID      16'h5D31
`define SRD_MODULE_VERSION 16'h0001

// Byte address width of the APB slave
`define SRD_APB_AW 4

`endif

// ==== source/srd_pkg.sv ====
/* Symbol-rate divider types
   Sample layout, rate selection encoding and register map */

`include "srd_cfg.svh"

package srd_pkg;

    //////////////////////////////
    // Stream payload
    //////////////////////////////

    // Complex sample, I in the upper half
    typedef struct packed {
        logic [`SRD_SAMPLE_W-1:0] i;
        logic [`SRD_SAMPLE_W-1:0] q;
    } iq_sample_t;

    // Rate selection, value 3 is reserved
    typedef enum logic [1:0] {
        RATE_FULL    = 2'd0,
        RATE_HALF    = 2'd1,
        RATE_QUARTER = 2'd2
    } symb_rate_sel_e;

    //////////////////////////////
    // Register byte offsets
    //////////////////////////////

    // ID in upper half, version in lower half
    localparam logic [`SRD_APB_AW-1:0] REG_ID       = 'h0;
    // Rate selection in bits 1:0
    localparam logic [`SRD_APB_AW-1:0] REG_SEL      = 'h4;
    // Base divide, read only
    localparam logic [`SRD_APB_AW-1:0] REG_DIV      = 'h8;
    // Accepted symbol count, write clears
    localparam logic [`SRD_APB_AW-1:0] REG_SYMB_CNT = 'hC;

endpackage

// ==== source/srd_apb_regs.sv ====
/* Symbol-rate divider APB register block
   Holds the rate selection and counts accepted input symbols */

`include "srd_cfg.svh"

module srd_apb_regs
    import srd_pkg::*;
(
    input  logic                   clk_ifc_avmm,
    input  logic                   rst_i,

    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`SRD_APB_AW-1:0] paddr_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,

    output symb_rate_sel_e         rate_sel_o,
    input  logic                   symb_accept_i
);

    //////////////////////////////
    // Signal declarations
    //////////////////////////////

    logic           access;
    logic           wr_access;
    logic           addr_err;
    logic           wr_err;
    logic           xfer_err;
    logic           sel_wr_en;
    logic           cnt_clr;
    logic [31:0]    rd_data;

    symb_rate_sel_e rate_sel_q;
    logic [15:0]    symb_cnt_q;

    //////////////////////////////
    // Access decode
    //////////////////////////////

    // Second cycle of a transfer
    assign access    = psel_i & penable_i;
    assign wr_access = access & pwrite_i;

    // No wait states
    assign pready_o = 1'b1;

    always_comb begin
        addr_err = 1'b0;
        wr_err   = 1'b0;
        case (paddr_i)
            REG_ID, REG_DIV: begin
                wr_err = pwrite_i;
            end
            REG_SEL: begin
                // Reserved encoding is rejected
                wr_err = pwrite_i & (pwdata_i[1:0] == 2'd3);
            end
            REG_SYMB_CNT: begin
                wr_err = 1'b0;
            end
            default: begin
                addr_err = 1'b1;
            end
        endcase
    end

    assign xfer_err  = addr_err | wr_err;
    assign pslverr_o = access & xfer_err;

    assign sel_wr_en = wr_access & (paddr_i == REG_SEL) & ~xfer_err;
    assign cnt_clr   = wr_access & (paddr_i == REG_SYMB_CNT);

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            rate_sel_q <= RATE_FULL;
        end else if (sel_wr_en) begin
            rate_sel_q <= symb_rate_sel_e'(pwdata_i[1:0]);
        end
    end

    // Wrapping count, clear wins over increment
    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            symb_cnt_q <= '0;
        end else if (cnt_clr) begin
            symb_cnt_q <= '0;
        end else if (symb_accept_i) begin
            symb_cnt_q <= symb_cnt_q + 16'd1;
        end
    end

    assign rate_sel_o = rate_sel_q;

    //////////////////////////////
    // Read data
    //////////////////////////////

    always_comb begin
        case (paddr_i)
            REG_ID:       rd_data = {`SRD_MODULE_ID, `SRD_MODULE_VERSION};
            REG_SEL:      rd_data = {30'd0, rate_sel_q};
            REG_DIV:      rd_data = 32'(`SRD_BASE_DIV);
            REG_SYMB_CNT: rd_data = {16'd0, symb_cnt_q};
            default:      rd_data = '0;
        endcase
    end

    // Only driven during a read access
    assign prdata_o = (access & ~pwrite_i) ? rd_data : '0;

endmodule

// ==== source/srd_sample_repeater.sv ====
/* Sample repeater for the transmit symbol-rate divider
   Presents each accepted sample for the selected number of output transfers */

`include "srd_cfg.svh"

module srd_sample_repeater
    import srd_pkg::*;
#(
    parameter type payload_t = logic [31:0]
) (
    input  logic           clk_ifc_avmm,
    input  logic           rst_i,

    input  symb_rate_sel_e rate_sel_i,

    input  logic           in_valid_i,
    output logic           in_ready_o,
    input  payload_t       in_data_i,

    output logic           out_valid_o,
    output payload_t       out_data_o,
    input  logic           out_ready_i,

    output logic           symb_accept_o
);

    //////////////////////////////
    // Constants and helpers
    //////////////////////////////

    // Largest repeat count is four times the base divide
    localparam int MAX_REP = `SRD_BASE_DIV * 4;
    localparam int CNT_W   = $clog2(MAX_REP + 1);

    // Total repetitions for one sample at the given rate
    function automatic logic [CNT_W-1:0] rep_count(input symb_rate_sel_e sel);
        int factor;
        case (sel)
            RATE_FULL:    factor = 1;
            RATE_HALF:    factor = 2;
            RATE_QUARTER: factor = 4;
            default:      factor = 1;
        endcase
        return CNT_W'(`SRD_BASE_DIV * factor);
    endfunction

    //////////////////////////////
    // Signal declarations
    //////////////////////////////

    payload_t         data_q;
    logic [CNT_W-1:0] rem_cnt_q;

    logic             in_fire;
    logic             out_fire;
    logic             last_rep;

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    // Holding a sample while repetitions remain
    assign out_valid_o = (rem_cnt_q != '0);
    assign out_data_o  = data_q;

    assign out_fire = out_valid_o & out_ready_i;
    assign last_rep = (rem_cnt_q == CNT_W'(1));

    // Empty, or the final repetition leaves this cycle
    assign in_ready_o = ~out_valid_o | (out_fire & last_rep);
    assign in_fire    = in_valid_i & in_ready_o;

    assign symb_accept_o = in_fire;

    //////////////////////////////
    // Repeat counter
    //////////////////////////////

    // Count is fixed when the sample is taken
    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            rem_cnt_q <= '0;
        end else if (in_fire) begin
            rem_cnt_q <= rep_count(rate_sel_i);
        end else if (out_fire) begin
            rem_cnt_q <= rem_cnt_q - CNT_W'(1);
        end
    end

    // Payload
    always_ff @(posedge clk_ifc_avmm) begin
        if (in_fire) begin
            data_q <= in_data_i;
        end
    end

endmodule

// ==== source/srd_top.sv ====
/* Transmit symbol-rate divider top level
   APB register block beside the sample repeater */

`include "srd_cfg.svh"

module srd_top
    import srd_pkg::*;
(
    input  logic                   clk_ifc_avmm,
    input  logic                   rst_i,

    // APB slave
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`SRD_APB_AW-1:0] paddr_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,

    // From the modulator
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  iq_sample_t             in_data_i,

    // To the DAC feed
    output logic                   out_valid_o,
    output iq_sample_t             out_data_o,
    input  logic                   out_ready_i
);

    //////////////////////////////
    // Internal wiring
    //////////////////////////////

    symb_rate_sel_e rate_sel;
    logic           symb_accept;

    srd_apb_regs u_regs (
        .clk_ifc_avmm  ( clk_ifc_avmm ),
        .rst_i         ( rst_i        ),
        .psel_i        ( psel_i       ),
        .penable_i     ( penable_i    ),
        .pwrite_i      ( pwrite_i     ),
        .paddr_i       ( paddr_i      ),
        .pwdata_i      ( pwdata_i     ),
        .prdata_o      ( prdata_o     ),
        .pready_o      ( pready_o     ),
        .pslverr_o     ( pslverr_o    ),
        .rate_sel_o    ( rate_sel     ),
        .symb_accept_i ( symb_accept  )
    );

    srd_sample_repeater #(
        .payload_t     ( iq_sample_t  )
    ) u_repeater (
        .clk_ifc_avmm  ( clk_ifc_avmm ),
        .rst_i         ( rst_i        ),
        .rate_sel_i    ( rate_sel     ),
        .in_valid_i    ( in_valid_i   ),
        .in_ready_o    ( in_ready_o   ),
        .in_data_i     ( in_data_i    ),
        .out_valid_o   ( out_valid_o  ),
        .out_data_o    ( out_data_o   ),
        .out_ready_i   ( out_ready_i  ),
        .symb_accept_o ( symb_accept  )
    );

endmodule

// ==== verif/srd_apb_tasks.svh ====
/* APB master tasks and LFSR random source
   Shared by the symbol-rate divider testbench */

`ifndef SRD_APB_TASKS_SVH
`define SRD_APB_TASKS_SVH

//////////////////////////////
// APB master
//////////////////////////////

// One setup cycle, then access until pready
task automatic apb_transfer(
    input  logic                   write,
    input  logic [`SRD_APB_AW-1:0] addr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata,
    output logic                   err
);
    int wait_cycles;
    wait_cycles = 0;
    rdata = '0;
    err = 1'b0;
    @(posedge clk_ifc_avmm);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_ifc_avmm);
    penable <= 1'b1;
    @(negedge clk_ifc_avmm);
    while (!pready && wait_cycles < APB_TIMEOUT) begin
        @(negedge clk_ifc_avmm);
        wait_cycles++;
    end
    if (!pready) begin
        $display("Timeout at %0t: APB slave never raised pready for address 0x%0h",
                 $time, addr);
        timeout_count++;
    end else begin
        // Response is stable in the middle of the access cycle
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_ifc_avmm);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    end
endtask

//////////////////////////////
// Random source
//////////////////////////////

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    int          b;
    value = '0;
    for (b = 0; b < width; b++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

`endif

// ==== verif/srd_tb.sv ====
/* Testbench for the transmit symbol-rate divider
   Register table, rate bursts with back-pressure and a stream scoreboard */

`include "srd_cfg.svh"

module srd_tb
    import srd_pkg::*;
;

    localparam int APB_TIMEOUT    = 16;
    localparam int STREAM_TIMEOUT = 2000;

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_BURST = 2'd2
    } op_e;

    // Target is an address for APB rows or a rate for bursts
    typedef struct packed {
        op_e         op;
        logic [31:0] target;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
    } row_t;

    logic                   clk_ifc_avmm;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`SRD_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   in_valid;
    logic                   in_ready;
    iq_sample_t             in_data;
    logic                   out_valid;
    iq_sample_t             out_data;
    logic                   out_ready;

    logic [31:0] lfsr_state;
    int          mismatch_count;
    int          timeout_count;
    row_t        rows[$];

    srd_top dut (
        .clk_ifc_avmm ( clk_ifc_avmm ),
        .rst_i        ( rst          ),
        .psel_i       ( psel         ),
        .penable_i    ( penable      ),
        .pwrite_i     ( pwrite       ),
        .paddr_i      ( paddr        ),
        .pwdata_i     ( pwdata       ),
        .prdata_o     ( prdata       ),
        .pready_o     ( pready       ),
        .pslverr_o    ( pslverr      ),
        .in_valid_i   ( in_valid     ),
        .in_ready_o   ( in_ready     ),
        .in_data_i    ( in_data      ),
        .out_valid_o  ( out_valid    ),
        .out_data_o   ( out_data     ),
        .out_ready_i  ( out_ready    )
    );

    initial begin
        clk_ifc_avmm = 1'b0;
        forever #10 clk_ifc_avmm = ~clk_ifc_avmm;
    end

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    `include "srd_apb_tasks.svh"

    //////////////////////////////
    // Stream scoreboard
    //////////////////////////////

    // Factor doubles with each rate step
    function automatic int expected_repeats(input int rate);
        return `SRD_BASE_DIV << rate;
    endfunction

    task automatic run_burst(input int rate, input int n_samples);
        logic [31:0] samples[$];
        logic [31:0] expected[$];
        logic [31:0] word;
        logic        in_xfer;
        logic        out_xfer;
        int          s;
        int          sent;
        int          received;
        int          cycles;
        for (s = 0; s < n_samples; s++) begin
            word = random_bits(32);
            samples.push_back(word);
            repeat (expected_repeats(rate)) expected.push_back(word);
        end
        sent = 0;
        received = 0;
        cycles = 0;
        @(posedge clk_ifc_avmm);
        in_valid  <= 1'b1;
        in_data   <= samples[0];
        out_ready <= (random_bits(1) != 32'd0);
        while (received < expected.size() && cycles < STREAM_TIMEOUT) begin
            // Handshakes seen here complete on the next rising edge
            @(negedge clk_ifc_avmm);
            in_xfer  = in_valid && in_ready;
            out_xfer = out_valid && out_ready;
            if (out_xfer) begin
                if (out_data !== expected[received]) begin
                    $display("Mismatch at %0t: output %0d of rate %0d is 0x%08h, expected 0x%08h",
                             $time, received, rate, out_data, expected[received]);
                    mismatch_count++;
                end
                received++;
            end
            if (in_xfer) begin
                sent++;
            end
            @(posedge clk_ifc_avmm);
            if (in_xfer) begin
                if (sent < n_samples) begin
                    in_data <= samples[sent];
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= (random_bits(1) != 32'd0);
            cycles++;
        end
        if (received < expected.size()) begin
            $display("Timeout at %0t: only %0d of %0d output samples arrived at rate %0d",
                     $time, received, expected.size(), rate);
            timeout_count++;
        end else begin
            @(negedge clk_ifc_avmm);
            if (out_valid !== 1'b0 || sent != n_samples) begin
                $display("Mismatch at %0t: stream not drained, %0d of %0d samples sent",
                         $time, sent, n_samples);
                mismatch_count++;
            end
        end
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    task automatic add_row(input op_e op, input logic [31:0] target, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_err);
        row_t row;
        row.op        = op;
        row.target    = target;
        row.wdata     = wdata;
        row.exp_rdata = exp_rdata;
        row.exp_err   = exp_err;
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row(OP_READ,  REG_ID, 0, {`SRD_MODULE_ID, `SRD_MODULE_VERSION}, 1'b0);
        add_row(OP_READ,  REG_SEL, 0, RATE_FULL, 1'b0);
        add_row(OP_READ,  REG_DIV, 0, `SRD_BASE_DIV, 1'b0);
        add_row(OP_READ,  REG_SYMB_CNT, 0, 0, 1'b0);
        // Selection readback
        add_row(OP_WRITE, REG_SEL, RATE_HALF, 0, 1'b0);
        add_row(OP_READ,  REG_SEL, 0, RATE_HALF, 1'b0);
        add_row(OP_WRITE, REG_SEL, RATE_QUARTER, 0, 1'b0);
        add_row(OP_READ,  REG_SEL, 0, RATE_QUARTER, 1'b0);
        add_row(OP_WRITE, REG_SEL, RATE_FULL, 0, 1'b0);
        add_row(OP_READ,  REG_SEL, 0, RATE_FULL, 1'b0);
        // Error cases leave the selection at half rate
        add_row(OP_WRITE, REG_SEL, RATE_HALF, 0, 1'b0);
        add_row(OP_READ,  'h2, 0, 0, 1'b1);
        add_row(OP_WRITE, 'h6, RATE_QUARTER, 0, 1'b1);
        add_row(OP_READ,  REG_SEL, 0, RATE_HALF, 1'b0);
        add_row(OP_WRITE, REG_ID, 32'h0000_0002, 0, 1'b1);
        add_row(OP_READ,  REG_SEL, 0, RATE_HALF, 1'b0);
        add_row(OP_WRITE, REG_DIV, 32'h0000_0002, 0, 1'b1);
        add_row(OP_READ,  REG_SEL, 0, RATE_HALF, 1'b0);
        add_row(OP_WRITE, REG_SEL, 32'h0000_0003, 0, 1'b1);
        add_row(OP_READ,  REG_SEL, 0, RATE_HALF, 1'b0);
        // Bursts at each rate with the selection changed while idle
        add_row(OP_WRITE, REG_SEL, RATE_FULL, 0, 1'b0);
        add_row(OP_BURST, RATE_FULL, 12, 0, 1'b0);
        add_row(OP_READ,  REG_SYMB_CNT, 0, 12, 1'b0);
        add_row(OP_WRITE, REG_SEL, RATE_HALF, 0, 1'b0);
        add_row(OP_BURST, RATE_HALF, 10, 0, 1'b0);
        add_row(OP_READ,  REG_SYMB_CNT, 0, 22, 1'b0);
        add_row(OP_WRITE, REG_SEL, RATE_QUARTER, 0, 1'b0);
        add_row(OP_BURST, RATE_QUARTER, 8, 0, 1'b0);
        add_row(OP_READ,  REG_SYMB_CNT, 0, 30, 1'b0);
        // Counter clear
        add_row(OP_WRITE, REG_SYMB_CNT, 32'h0000_1234, 0, 1'b0);
        add_row(OP_READ,  REG_SYMB_CNT, 0, 0, 1'b0);
        add_row(OP_WRITE, REG_SEL, RATE_FULL, 0, 1'b0);
        add_row(OP_BURST, RATE_FULL, 6, 0, 1'b0);
        add_row(OP_READ,  REG_SYMB_CNT, 0, 6, 1'b0);
    endtask

    task automatic apply_row(input row_t row);
        logic [31:0] rdata;
        logic        err;
        rdata = '0;
        err = 1'b0;
        if (row.op == OP_BURST) begin
            run_burst(int'(row.target), int'(row.wdata));
        end else begin
            apb_transfer(row.op == OP_WRITE, row.target[`SRD_APB_AW-1:0], row.wdata,
                         rdata, err);
            if (err !== row.exp_err) begin
                $display("Mismatch at %0t: pslverr %b at address 0x%0h, expected %b",
                         $time, err, row.target, row.exp_err);
                mismatch_count++;
            end
            if (row.op == OP_READ && !row.exp_err && rdata !== row.exp_rdata) begin
                $display("Mismatch at %0t: read 0x%08h at address 0x%0h, expected 0x%08h",
                         $time, rdata, row.target, row.exp_rdata);
                mismatch_count++;
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int r;
        lfsr_state     = 32'h86f8;
        mismatch_count = 0;
        timeout_count  = 0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk_ifc_avmm);
        rst <= 1'b0;
        @(negedge clk_ifc_avmm);
        if (out_valid !== 1'b0 || in_ready !== 1'b1 || pslverr !== 1'b0) begin
            $display("Mismatch at %0t: reset state out_valid %b in_ready %b pslverr %b",
                     $time, out_valid, in_ready, pslverr);
            mismatch_count++;
        end
        build_table();
        // A timeout ends the sequence
        for (r = 0; r < rows.size() && timeout_count == 0; r++) begin
            apply_row(rows[r]);
        end
        finish_run();
    end

endmodule

// ==== tb.f ====
+incdir+source
+incdir+verif
source/srd_pkg.sv
source/srd_apb_regs.sv
source/srd_sample_repeater.sv
source/srd_top.sv
verif/srd_tb.sv

// ==== Bender.yml ====
package:
  name: srd

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/srd_pkg.sv
      - source/srd_apb_regs.sv
      - source/srd_sample_repeater.sv
      - source/srd_top.sv
  - target: test
    include_dirs:
      - source
      - verif
    files:
      - verif/srd_tb.sv
